//--- rvfi_pkg.sv
////////////////////////////////////////////////////////////
// Widths, port indices and word types of the retirement
// trace. Import it in every tracer module to share the
// record layout between the pipeline stages.
////////////////////////////////////////////////////////////

package rvfi_pkg;

  // Data, PC and instruction width
  parameter int unsigned XLEN = 32;

  // Register file index width
  parameter int unsigned REG_ADDR_W = 5;

  // Retirement order counter width unless the top level overrides it
  parameter int unsigned ORDER_W_DEFAULT = 64;

  // Retire ports
  parameter int unsigned NRET = 2;

  // Non-memory instructions retire after execute
  parameter int unsigned PORT_EX = 0;

  // Loads and stores retire after writeback
  parameter int unsigned PORT_WB = 1;

  typedef logic [XLEN-1:0] xlen_t;

  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  // One enable bit per byte of a data word
  typedef logic [XLEN/8-1:0] mem_mask_t;

endpackage

//--- lsu_pkg.sv
////////////////////////////////////////////////////////////
// Load/store access size as driven by the core's decoder,
// and the byte mask that each size covers in the trace.
////////////////////////////////////////////////////////////

package lsu_pkg;

  import rvfi_pkg::*;

  // Value 3 is reserved and has no name
  typedef enum logic [1:0] {
    LSU_WORD = 2'd0,
    LSU_HALF = 2'd1,
    LSU_BYTE = 2'd2
  } lsu_type_e;

  // Accesses are aligned so the mask always starts at byte 0
  function automatic mem_mask_t lsu_byte_mask(lsu_type_e size);
    mem_mask_t mask;
    case (size)
      LSU_WORD: mask = 4'b1111;
      LSU_HALF: mask = 4'b0011;
      LSU_BYTE: mask = 4'b0001;
      default:  mask = 4'b0000;
    endcase
    return mask;
  endfunction

endpackage

//--- rvfi_decode_capture.sv
////////////////////////////////////////////////////////////
// First tracer stage. Registers the trace record of each
// instruction when decode completes and numbers it with
// the retirement order. The record stays pending until
// execute takes it.
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module rvfi_decode_capture import rvfi_pkg::*; import lsu_pkg::*; #(
  parameter int unsigned ORDER_W = ORDER_W_DEFAULT
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               id_valid_i,
  input  logic               id_decoding_i,
  input  logic               ex_ready_i,
  input  logic               insn_compressed_i,
  input  logic [15:0]        insn_c_i,
  input  xlen_t              insn_i,
  input  reg_addr_t          rs1_addr_i,
  input  reg_addr_t          rs2_addr_i,
  input  xlen_t              rs1_rdata_i,
  input  xlen_t              rs2_rdata_i,
  input  logic               rd_we_i,
  input  reg_addr_t          rd_addr_i,
  input  xlen_t              pc_id_i,
  input  xlen_t              pc_if_i,
  input  xlen_t              jump_target_i,
  input  logic               pc_set_i,
  input  logic               is_jump_i,
  input  logic               lsu_req_i,
  input  logic               lsu_we_i,
  input  lsu_type_e          lsu_type_i,
  output logic               pend_o,
  output logic [ORDER_W-1:0] order_o,
  output xlen_t              insn_o,
  output reg_addr_t          rs1_addr_o,
  output reg_addr_t          rs2_addr_o,
  output xlen_t              rs1_rdata_o,
  output xlen_t              rs2_rdata_o,
  output reg_addr_t          rd_addr_o,
  output xlen_t              pc_rdata_o,
  output xlen_t              pc_wdata_o,
  output mem_mask_t          rmask_o,
  output mem_mask_t          wmask_o,
  output logic               mem_o
);

  logic      id_done;
  mem_mask_t size_mask;

  assign id_done   = id_valid_i & id_decoding_i;
  assign size_mask = lsu_byte_mask(lsu_type_i);

  // A new record keeps the flag set even when execute takes the old one
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pend_o  <= 1'b0;
      order_o <= '0;
    end else if (id_done) begin
      pend_o  <= 1'b1;
      order_o <= order_o + ORDER_W'(1);
    end else if (ex_ready_i) begin
      pend_o  <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (id_done) begin
      // Compressed encodings are reported zero-extended
      insn_o      <= insn_compressed_i ? {16'b0, insn_c_i} : insn_i;
      rs1_addr_o  <= rs1_addr_i;
      rs2_addr_o  <= rs2_addr_i;
      rs1_rdata_o <= rs1_rdata_i;
      rs2_rdata_o <= rs2_rdata_i;
      rd_addr_o   <= rd_we_i ? rd_addr_i : '0;
      pc_rdata_o  <= pc_id_i;
      pc_wdata_o  <= (pc_set_i && is_jump_i) ? jump_target_i : pc_if_i;
      rmask_o     <= (lsu_req_i && !lsu_we_i) ? size_mask : '0;
      wmask_o     <= (lsu_req_i && lsu_we_i) ? size_mask : '0;
      mem_o       <= lsu_req_i;
    end
  end

endmodule

//--- rvfi_execute_stage.sv
////////////////////////////////////////////////////////////
// Second tracer stage. Completes the pending record when
// execute is ready. Non-memory instructions retire here on
// port 0 with a one-cycle valid. Loads and stores get their
// address and write data and move on to writeback.
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module rvfi_execute_stage import rvfi_pkg::*; #(
  parameter int unsigned ORDER_W = ORDER_W_DEFAULT
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               ex_ready_i,
  input  logic               pend_i,
  input  logic [ORDER_W-1:0] order_i,
  input  xlen_t              insn_i,
  input  reg_addr_t          rs1_addr_i,
  input  reg_addr_t          rs2_addr_i,
  input  xlen_t              rs1_rdata_i,
  input  xlen_t              rs2_rdata_i,
  input  reg_addr_t          rd_addr_i,
  input  xlen_t              pc_rdata_i,
  input  xlen_t              pc_wdata_i,
  input  mem_mask_t          rmask_i,
  input  mem_mask_t          wmask_i,
  input  logic               mem_i,
  input  xlen_t              rd_wdata_ex_i,
  input  logic               pc_set_i,
  input  logic               is_branch_i,
  input  xlen_t              branch_target_i,
  input  xlen_t              lsu_addr_i,
  input  xlen_t              lsu_wdata_i,
  // Port 0 record
  output logic               valid_o,
  output logic [ORDER_W-1:0] order_o,
  output xlen_t              insn_o,
  output reg_addr_t          rs1_addr_o,
  output reg_addr_t          rs2_addr_o,
  output xlen_t              rs1_rdata_o,
  output xlen_t              rs2_rdata_o,
  output reg_addr_t          rd_addr_o,
  output xlen_t              rd_wdata_o,
  output xlen_t              pc_rdata_o,
  output xlen_t              pc_wdata_o,
  // Record handed to writeback
  output logic               wb_pend_o,
  output logic [ORDER_W-1:0] wb_order_o,
  output xlen_t              wb_insn_o,
  output reg_addr_t          wb_rs1_addr_o,
  output reg_addr_t          wb_rs2_addr_o,
  output xlen_t              wb_rs1_rdata_o,
  output xlen_t              wb_rs2_rdata_o,
  output reg_addr_t          wb_rd_addr_o,
  output xlen_t              wb_pc_rdata_o,
  output xlen_t              wb_pc_wdata_o,
  output xlen_t              mem_addr_o,
  output xlen_t              mem_wdata_o,
  output mem_mask_t          rmask_o,
  output mem_mask_t          wmask_o
);

  logic  ex_done;
  xlen_t pc_wdata_d;

  assign ex_done    = ex_ready_i & pend_i;
  // A taken branch resolves here and overrides the fetch PC
  assign pc_wdata_d = (pc_set_i && is_branch_i) ? branch_target_i : pc_wdata_i;

  // Both strobes are single-cycle pulses
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_o   <= 1'b0;
      wb_pend_o <= 1'b0;
    end else begin
      valid_o   <= ex_done & ~mem_i;
      wb_pend_o <= ex_done & mem_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (ex_done && !mem_i) begin
      order_o     <= order_i;
      insn_o      <= insn_i;
      rs1_addr_o  <= rs1_addr_i;
      rs2_addr_o  <= rs2_addr_i;
      rs1_rdata_o <= rs1_rdata_i;
      rs2_rdata_o <= rs2_rdata_i;
      rd_addr_o   <= rd_addr_i;
      // x0 never reports write data
      rd_wdata_o  <= (rd_addr_i == '0) ? '0 : rd_wdata_ex_i;
      pc_rdata_o  <= pc_rdata_i;
      pc_wdata_o  <= pc_wdata_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (ex_done && mem_i) begin
      wb_order_o     <= order_i;
      wb_insn_o      <= insn_i;
      wb_rs1_addr_o  <= rs1_addr_i;
      wb_rs2_addr_o  <= rs2_addr_i;
      wb_rs1_rdata_o <= rs1_rdata_i;
      wb_rs2_rdata_o <= rs2_rdata_i;
      wb_rd_addr_o   <= rd_addr_i;
      wb_pc_rdata_o  <= pc_rdata_i;
      wb_pc_wdata_o  <= pc_wdata_d;
      mem_addr_o     <= lsu_addr_i;
      mem_wdata_o    <= lsu_wdata_i;
      rmask_o        <= rmask_i;
      wmask_o        <= wmask_i;
    end
  end

endmodule

//--- rvfi_writeback_stage.sv
////////////////////////////////////////////////////////////
// Last tracer stage. Waits with a load or store until the
// core's writeback is ready, then adds the result and load
// data and retires the record on port 1 for one cycle.
// The execute stage keeps the record stable meanwhile.
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module rvfi_writeback_stage import rvfi_pkg::*; #(
  parameter int unsigned ORDER_W = ORDER_W_DEFAULT
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               wb_ready_i,
  input  logic               pend_i,
  input  logic [ORDER_W-1:0] order_i,
  input  xlen_t              insn_i,
  input  reg_addr_t          rs1_addr_i,
  input  reg_addr_t          rs2_addr_i,
  input  xlen_t              rs1_rdata_i,
  input  xlen_t              rs2_rdata_i,
  input  reg_addr_t          rd_addr_i,
  input  xlen_t              pc_rdata_i,
  input  xlen_t              pc_wdata_i,
  input  xlen_t              mem_addr_i,
  input  xlen_t              mem_wdata_i,
  input  mem_mask_t          rmask_i,
  input  mem_mask_t          wmask_i,
  input  xlen_t              rd_wdata_wb_i,
  output logic               valid_o,
  output logic [ORDER_W-1:0] order_o,
  output xlen_t              insn_o,
  output reg_addr_t          rs1_addr_o,
  output reg_addr_t          rs2_addr_o,
  output xlen_t              rs1_rdata_o,
  output xlen_t              rs2_rdata_o,
  output reg_addr_t          rd_addr_o,
  output xlen_t              rd_wdata_o,
  output xlen_t              pc_rdata_o,
  output xlen_t              pc_wdata_o,
  output xlen_t              mem_addr_o,
  output mem_mask_t          mem_rmask_o,
  output mem_mask_t          mem_wmask_o,
  output xlen_t              mem_rdata_o,
  output xlen_t              mem_wdata_o
);

  logic wait_q;
  logic pending;
  logic wb_done;

  // Handoff pulse from execute or a record still waiting
  assign pending = pend_i | wait_q;
  assign wb_done = wb_ready_i & pending;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wait_q  <= 1'b0;
      valid_o <= 1'b0;
    end else begin
      wait_q  <= pending & ~wb_ready_i;
      valid_o <= wb_done;
    end
  end

  always_ff @(posedge clk_i) begin
    if (wb_done) begin
      order_o     <= order_i;
      insn_o      <= insn_i;
      rs1_addr_o  <= rs1_addr_i;
      rs2_addr_o  <= rs2_addr_i;
      rs1_rdata_o <= rs1_rdata_i;
      rs2_rdata_o <= rs2_rdata_i;
      rd_addr_o   <= rd_addr_i;
      rd_wdata_o  <= (rd_addr_i == '0) ? '0 : rd_wdata_wb_i;
      pc_rdata_o  <= pc_rdata_i;
      pc_wdata_o  <= pc_wdata_i;
      mem_addr_o  <= mem_addr_i;
      mem_rmask_o <= rmask_i;
      mem_wmask_o <= wmask_i;
      // Only loads return data, stores report zero
      mem_rdata_o <= (rmask_i != '0) ? rd_wdata_wb_i : '0;
      mem_wdata_o <= mem_wdata_i;
    end
  end

endmodule

//--- rvfi_tracer.sv
////////////////////////////////////////////////////////////
// Retirement tracer for a three-stage core. Connect the
// core's decode, execute and writeback signals. Port 0 of
// each trace output carries instructions retired after
// execute, port 1 the loads and stores after writeback.
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module rvfi_tracer import rvfi_pkg::*; import lsu_pkg::*; #(
  parameter int unsigned ORDER_W = ORDER_W_DEFAULT
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  // Decode
  input  logic                          id_valid_i,
  input  logic                          id_decoding_i,
  input  logic                          insn_compressed_i,
  input  logic [15:0]                   insn_c_i,
  input  xlen_t                         insn_i,
  input  reg_addr_t                     rs1_addr_i,
  input  reg_addr_t                     rs2_addr_i,
  input  xlen_t                         rs1_rdata_i,
  input  xlen_t                         rs2_rdata_i,
  input  logic                          rd_we_i,
  input  reg_addr_t                     rd_addr_i,
  input  xlen_t                         pc_id_i,
  input  xlen_t                         pc_if_i,
  input  xlen_t                         jump_target_i,
  input  logic                          pc_set_i,
  input  logic                          is_jump_i,
  input  logic                          lsu_req_i,
  input  logic                          lsu_we_i,
  input  lsu_type_e                     lsu_type_i,
  // Execute
  input  logic                          ex_ready_i,
  input  xlen_t                         rd_wdata_ex_i,
  input  xlen_t                         branch_target_ex_i,
  input  logic                          is_branch_ex_i,
  input  xlen_t                         lsu_addr_ex_i,
  input  xlen_t                         lsu_wdata_ex_i,
  // Writeback
  input  logic                          wb_ready_i,
  input  xlen_t                         rd_wdata_wb_i,
  // Trace ports, one element per retire port
  output logic [NRET-1:0]               rvfi_valid_o,
  output logic [NRET-1:0][ORDER_W-1:0]  rvfi_order_o,
  output xlen_t [NRET-1:0]              rvfi_insn_o,
  output reg_addr_t [NRET-1:0]          rvfi_rs1_addr_o,
  output reg_addr_t [NRET-1:0]          rvfi_rs2_addr_o,
  output xlen_t [NRET-1:0]              rvfi_rs1_rdata_o,
  output xlen_t [NRET-1:0]              rvfi_rs2_rdata_o,
  output reg_addr_t [NRET-1:0]          rvfi_rd_addr_o,
  output xlen_t [NRET-1:0]              rvfi_rd_wdata_o,
  output xlen_t [NRET-1:0]              rvfi_pc_rdata_o,
  output xlen_t [NRET-1:0]              rvfi_pc_wdata_o,
  output xlen_t [NRET-1:0]              rvfi_mem_addr_o,
  output mem_mask_t [NRET-1:0]          rvfi_mem_rmask_o,
  output mem_mask_t [NRET-1:0]          rvfi_mem_wmask_o,
  output xlen_t [NRET-1:0]              rvfi_mem_rdata_o,
  output xlen_t [NRET-1:0]              rvfi_mem_wdata_o
);

  // Decode to execute
  logic               id_pend;
  logic [ORDER_W-1:0] id_order;
  xlen_t              id_insn;
  reg_addr_t          id_rs1_addr;
  reg_addr_t          id_rs2_addr;
  xlen_t              id_rs1_rdata;
  xlen_t              id_rs2_rdata;
  reg_addr_t          id_rd_addr;
  xlen_t              id_pc_rdata;
  xlen_t              id_pc_wdata;
  mem_mask_t          id_rmask;
  mem_mask_t          id_wmask;
  logic               id_mem;

  // Execute to writeback
  logic               ex_pend;
  logic [ORDER_W-1:0] ex_order;
  xlen_t              ex_insn;
  reg_addr_t          ex_rs1_addr;
  reg_addr_t          ex_rs2_addr;
  xlen_t              ex_rs1_rdata;
  xlen_t              ex_rs2_rdata;
  reg_addr_t          ex_rd_addr;
  xlen_t              ex_pc_rdata;
  xlen_t              ex_pc_wdata;
  xlen_t              ex_mem_addr;
  xlen_t              ex_mem_wdata;
  mem_mask_t          ex_rmask;
  mem_mask_t          ex_wmask;

  // Port 0 never carries a memory access
  assign rvfi_mem_addr_o[PORT_EX]  = '0;
  assign rvfi_mem_rmask_o[PORT_EX] = '0;
  assign rvfi_mem_wmask_o[PORT_EX] = '0;
  assign rvfi_mem_rdata_o[PORT_EX] = '0;
  assign rvfi_mem_wdata_o[PORT_EX] = '0;

  rvfi_decode_capture #(
    .ORDER_W (ORDER_W)
  ) u_decode (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .id_valid_i        (id_valid_i),
    .id_decoding_i     (id_decoding_i),
    .ex_ready_i        (ex_ready_i),
    .insn_compressed_i (insn_compressed_i),
    .insn_c_i          (insn_c_i),
    .insn_i            (insn_i),
    .rs1_addr_i        (rs1_addr_i),
    .rs2_addr_i        (rs2_addr_i),
    .rs1_rdata_i       (rs1_rdata_i),
    .rs2_rdata_i       (rs2_rdata_i),
    .rd_we_i           (rd_we_i),
    .rd_addr_i         (rd_addr_i),
    .pc_id_i           (pc_id_i),
    .pc_if_i           (pc_if_i),
    .jump_target_i     (jump_target_i),
    .pc_set_i          (pc_set_i),
    .is_jump_i         (is_jump_i),
    .lsu_req_i         (lsu_req_i),
    .lsu_we_i          (lsu_we_i),
    .lsu_type_i        (lsu_type_i),
    .pend_o            (id_pend),
    .order_o           (id_order),
    .insn_o            (id_insn),
    .rs1_addr_o        (id_rs1_addr),
    .rs2_addr_o        (id_rs2_addr),
    .rs1_rdata_o       (id_rs1_rdata),
    .rs2_rdata_o       (id_rs2_rdata),
    .rd_addr_o         (id_rd_addr),
    .pc_rdata_o        (id_pc_rdata),
    .pc_wdata_o        (id_pc_wdata),
    .rmask_o           (id_rmask),
    .wmask_o           (id_wmask),
    .mem_o             (id_mem)
  );

  rvfi_execute_stage #(
    .ORDER_W (ORDER_W)
  ) u_execute (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .ex_ready_i      (ex_ready_i),
    .pend_i          (id_pend),
    .order_i         (id_order),
    .insn_i          (id_insn),
    .rs1_addr_i      (id_rs1_addr),
    .rs2_addr_i      (id_rs2_addr),
    .rs1_rdata_i     (id_rs1_rdata),
    .rs2_rdata_i     (id_rs2_rdata),
    .rd_addr_i       (id_rd_addr),
    .pc_rdata_i      (id_pc_rdata),
    .pc_wdata_i      (id_pc_wdata),
    .rmask_i         (id_rmask),
    .wmask_i         (id_wmask),
    .mem_i           (id_mem),
    .rd_wdata_ex_i   (rd_wdata_ex_i),
    .pc_set_i        (pc_set_i),
    .is_branch_i     (is_branch_ex_i),
    .branch_target_i (branch_target_ex_i),
    .lsu_addr_i      (lsu_addr_ex_i),
    .lsu_wdata_i     (lsu_wdata_ex_i),
    .valid_o         (rvfi_valid_o[PORT_EX]),
    .order_o         (rvfi_order_o[PORT_EX]),
    .insn_o          (rvfi_insn_o[PORT_EX]),
    .rs1_addr_o      (rvfi_rs1_addr_o[PORT_EX]),
    .rs2_addr_o      (rvfi_rs2_addr_o[PORT_EX]),
    .rs1_rdata_o     (rvfi_rs1_rdata_o[PORT_EX]),
    .rs2_rdata_o     (rvfi_rs2_rdata_o[PORT_EX]),
    .rd_addr_o       (rvfi_rd_addr_o[PORT_EX]),
    .rd_wdata_o      (rvfi_rd_wdata_o[PORT_EX]),
    .pc_rdata_o      (rvfi_pc_rdata_o[PORT_EX]),
    .pc_wdata_o      (rvfi_pc_wdata_o[PORT_EX]),
    .wb_pend_o       (ex_pend),
    .wb_order_o      (ex_order),
    .wb_insn_o       (ex_insn),
    .wb_rs1_addr_o   (ex_rs1_addr),
    .wb_rs2_addr_o   (ex_rs2_addr),
    .wb_rs1_rdata_o  (ex_rs1_rdata),
    .wb_rs2_rdata_o  (ex_rs2_rdata),
    .wb_rd_addr_o    (ex_rd_addr),
    .wb_pc_rdata_o   (ex_pc_rdata),
    .wb_pc_wdata_o   (ex_pc_wdata),
    .mem_addr_o      (ex_mem_addr),
    .mem_wdata_o     (ex_mem_wdata),
    .rmask_o         (ex_rmask),
    .wmask_o         (ex_wmask)
  );

  rvfi_writeback_stage #(
    .ORDER_W (ORDER_W)
  ) u_writeback (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .wb_ready_i    (wb_ready_i),
    .pend_i        (ex_pend),
    .order_i       (ex_order),
    .insn_i        (ex_insn),
    .rs1_addr_i    (ex_rs1_addr),
    .rs2_addr_i    (ex_rs2_addr),
    .rs1_rdata_i   (ex_rs1_rdata),
    .rs2_rdata_i   (ex_rs2_rdata),
    .rd_addr_i     (ex_rd_addr),
    .pc_rdata_i    (ex_pc_rdata),
    .pc_wdata_i    (ex_pc_wdata),
    .mem_addr_i    (ex_mem_addr),
    .mem_wdata_i   (ex_mem_wdata),
    .rmask_i       (ex_rmask),
    .wmask_i       (ex_wmask),
    .rd_wdata_wb_i (rd_wdata_wb_i),
    .valid_o       (rvfi_valid_o[PORT_WB]),
    .order_o       (rvfi_order_o[PORT_WB]),
    .insn_o        (rvfi_insn_o[PORT_WB]),
    .rs1_addr_o    (rvfi_rs1_addr_o[PORT_WB]),
    .rs2_addr_o    (rvfi_rs2_addr_o[PORT_WB]),
    .rs1_rdata_o   (rvfi_rs1_rdata_o[PORT_WB]),
    .rs2_rdata_o   (rvfi_rs2_rdata_o[PORT_WB]),
    .rd_addr_o     (rvfi_rd_addr_o[PORT_WB]),
    .rd_wdata_o    (rvfi_rd_wdata_o[PORT_WB]),
    .pc_rdata_o    (rvfi_pc_rdata_o[PORT_WB]),
    .pc_wdata_o    (rvfi_pc_wdata_o[PORT_WB]),
    .mem_addr_o    (rvfi_mem_addr_o[PORT_WB]),
    .mem_rmask_o   (rvfi_mem_rmask_o[PORT_WB]),
    .mem_wmask_o   (rvfi_mem_wmask_o[PORT_WB]),
    .mem_rdata_o   (rvfi_mem_rdata_o[PORT_WB]),
    .mem_wdata_o   (rvfi_mem_wdata_o[PORT_WB])
  );

endmodule

//--- tb_rvfi_tracer.sv
////////////////////////////////////////////////////////////
// Testbench for the retirement tracer. Issues one
// instruction at a time through decode, execute and
// writeback, predicts each trace record and checks every
// retirement pulse against a reference queue.
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module tb_rvfi_tracer import rvfi_pkg::*; import lsu_pkg::*;;

  localparam int unsigned ORDER_W = 64;
  localparam int TIMEOUT = 50;

  typedef struct packed {
    logic        port;
    logic [63:0] order;
    xlen_t       insn;
    reg_addr_t   rs1_addr;
    reg_addr_t   rs2_addr;
    xlen_t       rs1_rdata;
    xlen_t       rs2_rdata;
    reg_addr_t   rd_addr;
    xlen_t       rd_wdata;
    xlen_t       pc_rdata;
    xlen_t       pc_wdata;
    xlen_t       mem_addr;
    mem_mask_t   rmask;
    mem_mask_t   wmask;
    xlen_t       rdata;
    xlen_t       wdata;
  } exp_rec_t;

  logic clk_i;
  logic rst_ni;
  logic id_valid_i;
  logic id_decoding_i;
  logic insn_compressed_i;
  logic [15:0] insn_c_i;
  xlen_t insn_i;
  reg_addr_t rs1_addr_i;
  reg_addr_t rs2_addr_i;
  xlen_t rs1_rdata_i;
  xlen_t rs2_rdata_i;
  logic rd_we_i;
  reg_addr_t rd_addr_i;
  xlen_t pc_id_i;
  xlen_t pc_if_i;
  xlen_t jump_target_i;
  logic pc_set_i;
  logic is_jump_i;
  logic lsu_req_i;
  logic lsu_we_i;
  lsu_type_e lsu_type_i;
  logic ex_ready_i;
  xlen_t rd_wdata_ex_i;
  xlen_t branch_target_ex_i;
  logic is_branch_ex_i;
  xlen_t lsu_addr_ex_i;
  xlen_t lsu_wdata_ex_i;
  logic wb_ready_i;
  xlen_t rd_wdata_wb_i;

  logic [NRET-1:0]              rvfi_valid_o;
  logic [NRET-1:0][ORDER_W-1:0] rvfi_order_o;
  xlen_t [NRET-1:0]             rvfi_insn_o;
  reg_addr_t [NRET-1:0]         rvfi_rs1_addr_o;
  reg_addr_t [NRET-1:0]         rvfi_rs2_addr_o;
  xlen_t [NRET-1:0]             rvfi_rs1_rdata_o;
  xlen_t [NRET-1:0]             rvfi_rs2_rdata_o;
  reg_addr_t [NRET-1:0]         rvfi_rd_addr_o;
  xlen_t [NRET-1:0]             rvfi_rd_wdata_o;
  xlen_t [NRET-1:0]             rvfi_pc_rdata_o;
  xlen_t [NRET-1:0]             rvfi_pc_wdata_o;
  xlen_t [NRET-1:0]             rvfi_mem_addr_o;
  mem_mask_t [NRET-1:0]         rvfi_mem_rmask_o;
  mem_mask_t [NRET-1:0]         rvfi_mem_wmask_o;
  xlen_t [NRET-1:0]             rvfi_mem_rdata_o;
  xlen_t [NRET-1:0]             rvfi_mem_wdata_o;

  exp_rec_t    exp_q[$];
  string       name_q[$];
  bit [63:0]   order_exp;
  bit [63:0]   retired;
  bit [31:0]   lcg_state;
  int          cyc;
  int          ex_cyc;
  int          wb_cyc;
  int          value_errs;
  int          stray_errs;
  int          lost_errs;

  rvfi_tracer #(
    .ORDER_W (ORDER_W)
  ) u_dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Byte lanes covered by each access size, reserved covers none
  function automatic mem_mask_t size_mask(input lsu_type_e size);
    case (size)
      LSU_WORD: return 4'b1111;
      LSU_HALF: return 4'b0011;
      LSU_BYTE: return 4'b0001;
      default:  return 4'b0000;
    endcase
  endfunction

  task automatic check_field(input string name, input string field,
                             input logic [63:0] exp_v, input logic [63:0] act_v);
    assert (act_v === exp_v) else begin
      value_errs++;
      $display("ERR %s %s: expected %h, actual %h", name, field, exp_v, act_v);
    end
  endtask

  task automatic compare_port(input int p, input int exp_cyc);
    exp_rec_t e;
    string    name;
    if (exp_q.size() == 0) begin
      stray_errs++;
      $display("Port %0d retired an instruction that was never issued", p);
    end else begin
      e    = exp_q.pop_front();
      name = name_q.pop_front();
      retired++;
      check_field(name, "port", 64'(e.port), 64'(p));
      check_field(name, "cycle", 64'(exp_cyc), 64'(cyc));
      check_field(name, "order", e.order, 64'(rvfi_order_o[p]));
      check_field(name, "insn", 64'(e.insn), 64'(rvfi_insn_o[p]));
      check_field(name, "rs1_addr", 64'(e.rs1_addr), 64'(rvfi_rs1_addr_o[p]));
      check_field(name, "rs2_addr", 64'(e.rs2_addr), 64'(rvfi_rs2_addr_o[p]));
      check_field(name, "rs1_rdata", 64'(e.rs1_rdata), 64'(rvfi_rs1_rdata_o[p]));
      check_field(name, "rs2_rdata", 64'(e.rs2_rdata), 64'(rvfi_rs2_rdata_o[p]));
      check_field(name, "rd_addr", 64'(e.rd_addr), 64'(rvfi_rd_addr_o[p]));
      check_field(name, "rd_wdata", 64'(e.rd_wdata), 64'(rvfi_rd_wdata_o[p]));
      check_field(name, "pc_rdata", 64'(e.pc_rdata), 64'(rvfi_pc_rdata_o[p]));
      check_field(name, "pc_wdata", 64'(e.pc_wdata), 64'(rvfi_pc_wdata_o[p]));
      check_field(name, "mem_addr", 64'(e.mem_addr), 64'(rvfi_mem_addr_o[p]));
      check_field(name, "mem_rmask", 64'(e.rmask), 64'(rvfi_mem_rmask_o[p]));
      check_field(name, "mem_wmask", 64'(e.wmask), 64'(rvfi_mem_wmask_o[p]));
      check_field(name, "mem_rdata", 64'(e.rdata), 64'(rvfi_mem_rdata_o[p]));
      check_field(name, "mem_wdata", 64'(e.wdata), 64'(rvfi_mem_wdata_o[p]));
    end
  endtask

  // A retirement is due one cycle after the single ready strobe of its stage
  always @(posedge clk_i) begin
    if (rst_ni) begin
      if (rvfi_valid_o[PORT_EX]) begin
        compare_port(int'(PORT_EX), ex_cyc + 1);
      end
      if (rvfi_valid_o[PORT_WB]) begin
        compare_port(int'(PORT_WB), wb_cyc + 1);
      end
      if (ex_ready_i) begin
        ex_cyc = cyc;
      end
      if (wb_ready_i) begin
        wb_cyc = cyc;
      end
    end
    cyc++;
  end

  // Runs one instruction through all stages and waits for its retirement
  task automatic run_instr(input string name, input bit mem, input bit store,
                           input lsu_type_e size, input bit rd_we, input reg_addr_t rd,
                           input bit compr, input bit jump, input bit branch,
                           input int ex_wait, input int wb_wait);
    exp_rec_t    e;
    logic [31:0] r;
    int          n;
    e = '0;
    r = next_rand();
    order_exp++;
    @(negedge clk_i);
    id_valid_i        = 1'b1;
    id_decoding_i     = 1'b1;
    insn_compressed_i = compr;
    insn_i            = next_rand();
    insn_c_i          = 16'(next_rand());
    rs1_addr_i        = r[4:0];
    rs2_addr_i        = r[9:5];
    rs1_rdata_i       = next_rand();
    rs2_rdata_i       = next_rand();
    rd_we_i           = rd_we;
    rd_addr_i         = rd;
    pc_id_i           = next_rand();
    pc_if_i           = next_rand();
    jump_target_i     = next_rand();
    pc_set_i          = jump;
    // Jump flag alone must not redirect without pc_set
    is_jump_i         = jump | r[10];
    lsu_req_i         = mem;
    lsu_we_i          = store;
    lsu_type_i        = size;
    @(negedge clk_i);
    id_valid_i    = r[11];
    id_decoding_i = 1'b0;
    pc_set_i      = 1'b0;
    repeat (ex_wait) @(negedge clk_i);
    ex_ready_i         = 1'b1;
    rd_wdata_ex_i      = next_rand();
    pc_set_i           = branch;
    is_branch_ex_i     = branch | r[12];
    branch_target_ex_i = next_rand();
    lsu_addr_ex_i      = next_rand();
    lsu_wdata_ex_i     = store ? next_rand() : '0;
    @(negedge clk_i);
    ex_ready_i = 1'b0;
    pc_set_i   = 1'b0;
    if (mem) begin
      repeat (wb_wait) @(negedge clk_i);
      wb_ready_i    = 1'b1;
      rd_wdata_wb_i = next_rand();
      @(negedge clk_i);
      wb_ready_i = 1'b0;
    end
    e.port      = mem;
    e.order     = order_exp;
    e.insn      = compr ? {16'b0, insn_c_i} : insn_i;
    e.rs1_addr  = rs1_addr_i;
    e.rs2_addr  = rs2_addr_i;
    e.rs1_rdata = rs1_rdata_i;
    e.rs2_rdata = rs2_rdata_i;
    e.rd_addr   = rd_we ? rd : '0;
    e.rd_wdata  = (e.rd_addr == '0) ? '0 : (mem ? rd_wdata_wb_i : rd_wdata_ex_i);
    e.pc_rdata  = pc_id_i;
    e.pc_wdata  = branch ? branch_target_ex_i : (jump ? jump_target_i : pc_if_i);
    if (mem) begin
      e.mem_addr = lsu_addr_ex_i;
      e.rmask    = store ? '0 : size_mask(size);
      e.wmask    = store ? size_mask(size) : '0;
      e.rdata    = (e.rmask != '0) ? rd_wdata_wb_i : '0;
      e.wdata    = lsu_wdata_ex_i;
    end
    exp_q.push_back(e);
    name_q.push_back(name);
    n = 0;
    while (retired < order_exp && n < TIMEOUT) begin
      @(negedge clk_i);
      n++;
    end
    if (retired < order_exp) begin
      lost_errs++;
      $display("Instruction %0d of %s never retired", order_exp, name);
    end
  endtask

  initial begin
    logic [31:0] r;
    lcg_state = 32'h73326124;
    rst_ni    = 1'b0;
    {id_valid_i, id_decoding_i, insn_compressed_i, insn_c_i, insn_i} = '0;
    {rs1_addr_i, rs2_addr_i, rs1_rdata_i, rs2_rdata_i, rd_we_i, rd_addr_i} = '0;
    {pc_id_i, pc_if_i, jump_target_i, pc_set_i, is_jump_i, lsu_req_i, lsu_we_i} = '0;
    lsu_type_i = LSU_WORD;
    {ex_ready_i, rd_wdata_ex_i, branch_target_ex_i, is_branch_ex_i} = '0;
    {lsu_addr_ex_i, lsu_wdata_ex_i, wb_ready_i, rd_wdata_wb_i} = '0;
    repeat (8) @(negedge clk_i);
    rst_ni = 1'b1;

    run_instr("alu", 1'b0, 1'b0, LSU_WORD, 1'b1, 5'd5, 1'b0, 1'b0, 1'b0, 0, 0);
    run_instr("no_rd_write", 1'b0, 1'b0, LSU_WORD, 1'b0, 5'd9, 1'b0, 1'b0, 1'b0, 0, 0);
    run_instr("x0_write", 1'b0, 1'b0, LSU_WORD, 1'b1, 5'd0, 1'b0, 1'b0, 1'b0, 0, 0);
    run_instr("compressed", 1'b0, 1'b0, LSU_WORD, 1'b1, 5'd3, 1'b1, 1'b0, 1'b0, 0, 0);
    run_instr("jump", 1'b0, 1'b0, LSU_WORD, 1'b1, 5'd1, 1'b0, 1'b1, 1'b0, 0, 0);
    run_instr("branch", 1'b0, 1'b0, LSU_WORD, 1'b0, 5'd0, 1'b0, 1'b0, 1'b1, 0, 0);
    run_instr("load_word", 1'b1, 1'b0, LSU_WORD, 1'b1, 5'd10, 1'b0, 1'b0, 1'b0, 0, 0);
    run_instr("load_half", 1'b1, 1'b0, LSU_HALF, 1'b1, 5'd11, 1'b0, 1'b0, 1'b0, 0, 0);
    run_instr("load_byte", 1'b1, 1'b0, LSU_BYTE, 1'b1, 5'd12, 1'b0, 1'b0, 1'b0, 0, 0);
    run_instr("load_reserved", 1'b1, 1'b0, lsu_type_e'(2'd3), 1'b1, 5'd13, 1'b0, 1'b0, 1'b0,
              0, 0);
    run_instr("store_word", 1'b1, 1'b1, LSU_WORD, 1'b0, 5'd0, 1'b0, 1'b0, 1'b0, 0, 0);
    run_instr("store_half", 1'b1, 1'b1, LSU_HALF, 1'b0, 5'd0, 1'b0, 1'b0, 1'b0, 0, 0);
    run_instr("store_byte", 1'b1, 1'b1, LSU_BYTE, 1'b0, 5'd0, 1'b0, 1'b0, 1'b0, 0, 0);

    // Random kinds with stalls in execute and writeback
    for (int i = 0; i < 40; i++) begin
      r = next_rand();
      run_instr("stall_random", r[0], r[1], lsu_type_e'(r[3:2]), r[4], r[9:5],
                r[10], r[11], r[12], int'(r[15:13]), int'(r[18:16]));
    end

    repeat (4) @(negedge clk_i);
    if (exp_q.size() != 0) begin
      lost_errs++;
      $display("%0d issued instructions are still waiting for retirement", exp_q.size());
    end
    $display("Errors: %0d value, %0d unexpected retirement, %0d missing retirement",
             value_errs, stray_errs, lost_errs);
    if (value_errs + stray_errs + lost_errs == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

//--- project.f
rvfi_pkg.sv
lsu_pkg.sv
rvfi_decode_capture.sv
rvfi_execute_stage.sv
rvfi_writeback_stage.sv
rvfi_tracer.sv
tb_rvfi_tracer.sv

//--- Makefile
# Verilator lint and simulation of the retirement tracer

TOOL     := verilator
FLAGS    := --timing --assert
TOP      := tb_rvfi_tracer
FILELIST := project.f
OBJ_DIR  := obj_dir
PASS_MSG := test passed

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# Fails unless the run prints the pass line
sim:
	$(TOOL) --binary $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
